// File: rtl/mp_core_pkg.sv
`default_nettype none

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Coprocessor datapath definitions
// Word sizes, register addressing, step count
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package mp_core_pkg;

    // One CPR word and the double word built from two of them
    localparam int XLEN = 32;
    localparam int DLEN = 2 * XLEN;

    localparam int NUM_CPR = 16;
    localparam int CPR_AW  = $clog2(NUM_CPR);

    // Operand reads per instruction
    localparam int NUM_RD = 3;

    typedef logic [CPR_AW-1:0] cpr_addr_t;

    // Enough for the three-step instructions
    typedef logic [1:0] mp_step_t;

endpackage

`default_nettype wire

// File: rtl/mp_isa_pkg.sv
`default_nettype none

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Coprocessor instruction encoding
// Subclass codes, word layout, step table
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package mp_isa_pkg;

    import mp_core_pkg::*;

    localparam int INSTR_W    = 32;
    localparam int SUBCLASS_W = 5;
    // Top bit of the rs3 / imm4 field
    localparam int FIELD_MSB  = 20;

    typedef enum logic [SUBCLASS_W-1:0] {
        sc_mequ     = 5'h00,
        sc_mlte     = 5'h01,
        sc_mgte     = 5'h02,
        sc_madd_3   = 5'h03,
        sc_madd_2   = 5'h04,
        sc_msub_3   = 5'h05,
        sc_msub_2   = 5'h06,
        sc_msll_i   = 5'h07,
        sc_msll     = 5'h08,
        sc_msrl_i   = 5'h09,
        sc_msrl     = 5'h0a,
        sc_macc_1   = 5'h0b,
        sc_mmul_3   = 5'h0c,
        sc_mclmul_3 = 5'h0d
    } mp_subclass_e;

    typedef struct packed {
        logic [INSTR_W-1:FIELD_MSB+1] unused;
        cpr_addr_t                    rs3;
        cpr_addr_t                    rs2;
        cpr_addr_t                    rs1;
        cpr_addr_t                    rd;
        mp_subclass_e                 subclass;
    } mp_instr_reg_t;

    // Shift amount replaces rs3
    typedef struct packed {
        logic [INSTR_W-1:FIELD_MSB+1] unused;
        logic [3:0]                   imm4;
        cpr_addr_t                    rs2;
        cpr_addr_t                    rs1;
        cpr_addr_t                    rd;
        mp_subclass_e                 subclass;
    } mp_instr_imm_t;

    typedef union packed {
        mp_instr_reg_t r;
        mp_instr_imm_t i;
    } mp_instr_t;

    // Steps per subclass, unknown codes finish in one
    localparam mp_step_t mp_num_steps [2**SUBCLASS_W] = '{
        sc_mequ:     2'd1, sc_mlte:   2'd1, sc_mgte:   2'd1,
        sc_madd_2:   2'd2, sc_msub_2: 2'd2, sc_macc_1: 2'd2,
        sc_msll_i:   2'd2, sc_msll:   2'd2, sc_msrl_i: 2'd2,
        sc_msrl:     2'd2, sc_mclmul_3: 2'd2,
        sc_madd_3:   2'd3, sc_msub_3: 2'd3, sc_mmul_3: 2'd3,
        default:     2'd1
    };

endpackage

`default_nettype wire

// File: rtl/mp_issue_if.sv
`timescale 1ns/1ps
`default_nettype none

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Issue bundle
// Decoded instruction and operands to the ALU
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

interface mp_issue_if;

    import mp_core_pkg::*;
    import mp_isa_pkg::*;

    logic            issue_valid;
    mp_instr_t       instr;
    logic [XLEN-1:0] gpr;
    logic [XLEN-1:0] op_rs1;
    logic [XLEN-1:0] op_rs2;
    logic [XLEN-1:0] op_rs3;
    // High in the last ALU step only
    logic            step_done;

    modport dec (output issue_valid, instr, gpr, op_rs1, op_rs2, op_rs3,
                 input  step_done);

    modport alu (input  issue_valid, instr, gpr, op_rs1, op_rs2, op_rs3,
                 output step_done);

    modport wb  (input  instr, issue_valid, step_done);

endinterface

`default_nettype wire

// File: rtl/mp_decode.sv
`timescale 1ns/1ps
`default_nettype none

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Instruction decode
// Accepts an instruction, fetches its operands
// and holds both until the ALU finishes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module mp_decode (
    input  logic                         g_clk,
    input  logic                         g_resetn,
    input  logic                         instr_valid_i,
    input  mp_isa_pkg::mp_instr_t        instr_i,
    input  logic [mp_core_pkg::XLEN-1:0] gpr_rs1_i,
    output logic                         busy_o,
    output mp_core_pkg::cpr_addr_t       rd_addr_o [mp_core_pkg::NUM_RD],
    input  logic [mp_core_pkg::XLEN-1:0] rd_data_i [mp_core_pkg::NUM_RD],
    mp_issue_if.dec                      issue
);

    import mp_isa_pkg::*;

    logic accept;
    logic fetch_q;
    logic done_q;
    logic imm_shift;

    assign accept = instr_valid_i && !busy_o;

    // Read addresses come from the held instruction
    assign imm_shift = issue.instr.i.subclass inside {sc_msll_i, sc_msrl_i};

    always_comb begin
        rd_addr_o[0] = issue.instr.r.rs1;
        rd_addr_o[1] = issue.instr.r.rs2;
        // Immediate shifts hold the shift amount in place of rs3
        if (imm_shift) begin
            rd_addr_o[2] = '0;
        end else begin
            rd_addr_o[2] = issue.instr.r.rs3;
        end
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            busy_o            <= 1'b0;
            fetch_q           <= 1'b0;
            done_q            <= 1'b0;
            issue.issue_valid <= 1'b0;
        end else begin
            fetch_q <= accept;
            // Lines up with instr_done_o in writeback
            done_q  <= issue.step_done;
            if (accept) begin
                busy_o <= 1'b1;
            end else if (done_q) begin
                busy_o <= 1'b0;
            end
            if (fetch_q) begin
                issue.issue_valid <= 1'b1;
            end else if (done_q) begin
                issue.issue_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge g_clk) begin
        if (accept) begin
            issue.instr <= instr_i;
            issue.gpr   <= gpr_rs1_i;
        end
        if (fetch_q) begin
            issue.op_rs1 <= rd_data_i[0];
            issue.op_rs2 <= rd_data_i[1];
            issue.op_rs3 <= rd_data_i[2];
        end
    end

    // Nothing new is taken while an instruction is still in flight
    a_no_accept_busy: assert property (@(posedge g_clk) disable iff (!g_resetn)
        accept |-> !fetch_q && !issue.issue_valid);

endmodule

`default_nettype wire

// File: rtl/mp_cpr_file.sv
`timescale 1ns/1ps
`default_nettype none

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Coprocessor register file
// 16 x 32 bits, three read ports, one write
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module mp_cpr_file (
    input  logic                         g_clk,
    input  logic                         g_resetn,
    input  mp_core_pkg::cpr_addr_t       rd_addr_i [mp_core_pkg::NUM_RD],
    output logic [mp_core_pkg::XLEN-1:0] rd_data_o [mp_core_pkg::NUM_RD],
    input  logic                         we_i,
    input  mp_core_pkg::cpr_addr_t       waddr_i,
    input  logic [mp_core_pkg::XLEN-1:0] wdata_i
);

    import mp_core_pkg::*;

    logic [XLEN-1:0] regs_q [NUM_CPR];

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            regs_q <= '{default: '0};
        end else if (we_i) begin
            regs_q[waddr_i] <= wdata_i;
        end
    end

    // Combinational reads, no bypass of a same-cycle write
    always_comb begin
        for (int p = 0; p < NUM_RD; p++) begin
            rd_data_o[p] = regs_q[rd_addr_i[p]];
        end
    end

    a_waddr_known: assert property (@(posedge g_clk) disable iff (!g_resetn)
        we_i |-> !$isunknown(waddr_i));

endmodule

`default_nettype wire

// File: rtl/mp_malu.sv
`timescale 1ns/1ps
`default_nettype none

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Multi-precision ALU
// Compare, add/sub, multiply, clmul and shift
// over one to three steps
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module mp_malu (
    input  logic                         g_clk,
    input  logic                         g_resetn,
    mp_issue_if.alu                      issue,
    output logic                         res_valid_o,
    output logic                         res_hi_o,
    output logic [mp_core_pkg::XLEN-1:0] res_data_o
);

    import mp_core_pkg::*;
    import mp_isa_pkg::*;

    mp_subclass_e    sc;
    mp_step_t        step_q;
    mp_step_t        n_steps;
    logic            drained_q;
    logic            active;
    logic            step0;
    logic            last_step;
    logic            is_cmp;
    logic            is_sub;
    logic            is_macc;
    logic            is_mul;
    logic            is_clmul;
    logic            is_imm_shf;
    logic            is_reg_shf;
    logic            shf_right;
    logic            cmp_eq;
    logic            cmp_lt;
    logic            cmp_bit;
    logic [5:0]      shamt;
    logic [DLEN-1:0] tmp_q;
    logic [DLEN-1:0] add_lhs;
    logic [DLEN-1:0] add_rhs;
    logic [DLEN-1:0] add_res;
    logic [DLEN-1:0] mul_res;
    logic [DLEN-1:0] clmul_res;
    logic [DLEN-1:0] shf_in;
    logic [DLEN-1:0] shf_res;
    logic [DLEN-1:0] lo_res;

    assign sc         = issue.instr.r.subclass;
    assign n_steps    = mp_num_steps[sc];
    assign is_cmp     = sc inside {sc_mequ, sc_mlte, sc_mgte};
    assign is_sub     = sc inside {sc_msub_2, sc_msub_3};
    assign is_macc    = sc == sc_macc_1;
    assign is_mul     = sc == sc_mmul_3;
    assign is_clmul   = sc == sc_mclmul_3;
    assign is_imm_shf = sc inside {sc_msll_i, sc_msrl_i};
    assign is_reg_shf = sc inside {sc_msll, sc_msrl};
    assign shf_right  = sc inside {sc_msrl_i, sc_msrl};

    // Drained covers the done cycle before issue_valid drops
    assign active    = issue.issue_valid && !drained_q;
    assign step0     = step_q == 2'd0;
    assign last_step = active && (step_q == n_steps - 2'd1);

    assign issue.step_done = last_step;

    always_ff @(posedge g_clk) begin
        if (!g_resetn || !issue.issue_valid) begin
            step_q    <= '0;
            drained_q <= 1'b0;
        end else if (last_step) begin
            step_q    <= '0;
            drained_q <= 1'b1;
        end else if (active) begin
            step_q <= step_q + 2'd1;
        end
    end

    // Comparator, equal results fall back on the chain flag
    assign cmp_eq = issue.op_rs2 == issue.op_rs3;
    assign cmp_lt = issue.op_rs2 <  issue.op_rs3;

    always_comb begin
        case (sc)
            sc_mequ: cmp_bit = cmp_eq && |issue.gpr;
            sc_mlte: cmp_bit = cmp_lt || (cmp_eq && |issue.gpr);
            sc_mgte: cmp_bit = !(cmp_lt || cmp_eq) || (cmp_eq && |issue.gpr);
            default: cmp_bit = 1'b0;
        endcase
    end

    // Shared adder: rs1 first, then tmp plus rs3 or its borrow bit
    assign add_lhs = step0 ? DLEN'(issue.op_rs1) : tmp_q;

    always_comb begin
        if (step0) begin
            add_rhs = is_macc ? {issue.op_rs2, issue.op_rs3} : DLEN'(issue.op_rs2);
        end else if (is_sub) begin
            add_rhs = DLEN'(issue.op_rs3[0]);
        end else begin
            add_rhs = DLEN'(issue.op_rs3);
        end
    end

    assign add_res = is_sub ? add_lhs - add_rhs : add_lhs + add_rhs;

    assign mul_res = DLEN'(issue.op_rs1) * DLEN'(issue.op_rs2);

    // rs3 seeds the xor tree, so it lands in the low word
    always_comb begin
        clmul_res = DLEN'(issue.op_rs3);
        for (int i = 0; i < XLEN; i++) begin
            if (issue.op_rs2[i]) begin
                clmul_res = clmul_res ^ (DLEN'(issue.op_rs1) << i);
            end
        end
    end

    assign shamt  = is_imm_shf ? 6'(issue.instr.i.imm4) : issue.op_rs3[5:0];
    assign shf_in = {issue.op_rs2, issue.op_rs1};

    always_comb begin
        if (is_reg_shf && |issue.op_rs3[XLEN-1:6]) begin
            shf_res = '0;
        end else if (shf_right) begin
            shf_res = shf_in >> shamt;
        end else begin
            shf_res = shf_in << shamt;
        end
    end

    assign lo_res = (is_imm_shf || is_reg_shf) ? shf_res :
                    is_clmul                   ? clmul_res : add_res;

    // High word waits here for the last step
    always_ff @(posedge g_clk) begin
        if (active && !last_step) begin
            tmp_q <= (step0 && is_mul) ? mul_res : lo_res;
        end
    end

    // Three-step instructions produce nothing in step 0
    assign res_valid_o = active && (!step0 || n_steps != 2'd3);
    assign res_hi_o    = last_step && n_steps != 2'd1;
    assign res_data_o  = res_hi_o ? tmp_q[DLEN-1:XLEN] :
                         is_cmp   ? XLEN'(cmp_bit)     : lo_res[XLEN-1:0];

    a_step_bound: assert property (@(posedge g_clk) disable iff (!g_resetn)
        issue.issue_valid |-> step_q < n_steps);

endmodule

`default_nettype wire

// File: rtl/mp_writeback.sv
`timescale 1ns/1ps
`default_nettype none

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Result writeback
// Picks the destination and registers the write
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module mp_writeback (
    input  logic                         g_clk,
    input  logic                         g_resetn,
    mp_issue_if.wb                       issue,
    input  logic                         res_valid_i,
    input  logic                         res_hi_i,
    input  logic [mp_core_pkg::XLEN-1:0] res_data_i,
    output logic                         cpr_we_o,
    output mp_core_pkg::cpr_addr_t       cpr_waddr_o,
    output logic [mp_core_pkg::XLEN-1:0] cpr_wdata_o,
    output logic                         wb_valid_o,
    output mp_core_pkg::cpr_addr_t       wb_addr_o,
    output logic [mp_core_pkg::XLEN-1:0] wb_data_o,
    output logic                         instr_done_o
);

    import mp_core_pkg::*;
    import mp_isa_pkg::*;

    cpr_addr_t       dest;
    cpr_addr_t       addr_q;
    logic [XLEN-1:0] data_q;
    logic            we_q;

    // macc_1 accumulates in place over rs2:rs3
    always_comb begin
        if (issue.instr.r.subclass == sc_macc_1) begin
            dest = res_hi_i ? issue.instr.r.rs2 : issue.instr.r.rs3;
        end else begin
            dest = res_hi_i ? issue.instr.r.rd + cpr_addr_t'(1) : issue.instr.r.rd;
        end
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            we_q         <= 1'b0;
            instr_done_o <= 1'b0;
        end else begin
            we_q         <= res_valid_i;
            instr_done_o <= issue.step_done;
        end
    end

    always_ff @(posedge g_clk) begin
        if (res_valid_i) begin
            addr_q <= dest;
            data_q <= res_data_i;
        end
    end

    assign cpr_we_o    = we_q;
    assign cpr_waddr_o = addr_q;
    assign cpr_wdata_o = data_q;
    assign wb_valid_o  = we_q;
    assign wb_addr_o   = addr_q;
    assign wb_data_o   = data_q;

    // Every instruction ends on a result word
    a_last_word: assert property (@(posedge g_clk) disable iff (!g_resetn)
        issue.step_done |-> res_valid_i && issue.issue_valid);

endmodule

`default_nettype wire

// File: rtl/mp_cop_top.sv
`timescale 1ns/1ps
`default_nettype none

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Multi-precision coprocessor top level
// Decode, register file, ALU and writeback
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module mp_cop_top (
    input  logic                            g_clk,
    input  logic                            g_resetn,
    input  logic                            instr_valid_i,
    input  logic [mp_isa_pkg::INSTR_W-1:0]  instr_i,
    input  logic [mp_core_pkg::XLEN-1:0]    gpr_rs1_i,
    output logic                            busy_o,
    input  logic                            host_we_i,
    input  mp_core_pkg::cpr_addr_t          host_addr_i,
    input  logic [mp_core_pkg::XLEN-1:0]    host_wdata_i,
    output logic                            wb_valid_o,
    output mp_core_pkg::cpr_addr_t          wb_addr_o,
    output logic [mp_core_pkg::XLEN-1:0]    wb_data_o,
    output logic                            instr_done_o
);

    import mp_core_pkg::*;

    cpr_addr_t       rd_addr [NUM_RD];
    logic [XLEN-1:0] rd_data [NUM_RD];
    logic            res_valid;
    logic            res_hi;
    logic [XLEN-1:0] res_data;
    logic            cpr_we;
    cpr_addr_t       cpr_waddr;
    logic [XLEN-1:0] cpr_wdata;

    mp_issue_if u_issue ();

    mp_decode u_decode (
        .g_clk         (g_clk),
        .g_resetn      (g_resetn),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .gpr_rs1_i     (gpr_rs1_i),
        .busy_o        (busy_o),
        .rd_addr_o     (rd_addr),
        .rd_data_i     (rd_data),
        .issue         (u_issue.dec)
    );

    // Writeback wins, host writes are locked out while busy
    mp_cpr_file u_cpr_file (
        .g_clk     (g_clk),
        .g_resetn  (g_resetn),
        .rd_addr_i (rd_addr),
        .rd_data_o (rd_data),
        .we_i      (cpr_we || (host_we_i && !busy_o)),
        .waddr_i   (cpr_we ? cpr_waddr : host_addr_i),
        .wdata_i   (cpr_we ? cpr_wdata : host_wdata_i)
    );

    mp_malu u_malu (
        .g_clk       (g_clk),
        .g_resetn    (g_resetn),
        .issue       (u_issue.alu),
        .res_valid_o (res_valid),
        .res_hi_o    (res_hi),
        .res_data_o  (res_data)
    );

    mp_writeback u_writeback (
        .g_clk        (g_clk),
        .g_resetn     (g_resetn),
        .issue        (u_issue.wb),
        .res_valid_i  (res_valid),
        .res_hi_i     (res_hi),
        .res_data_i   (res_data),
        .cpr_we_o     (cpr_we),
        .cpr_waddr_o  (cpr_waddr),
        .cpr_wdata_o  (cpr_wdata),
        .wb_valid_o   (wb_valid_o),
        .wb_addr_o    (wb_addr_o),
        .wb_data_o    (wb_data_o),
        .instr_done_o (instr_done_o)
    );

endmodule

`default_nettype wire

// File: testbench/tb_mp_model.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Coprocessor reference model
// Result prediction and compare tasks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef TB_MP_MODEL_SVH
`define TB_MP_MODEL_SVH

// Compares in one step, 64-bit sums and the multiply in three
function automatic mp_step_t model_steps(input mp_subclass_e sc);
    case (sc)
        sc_mequ, sc_mlte, sc_mgte:       model_steps = 2'd1;
        sc_madd_3, sc_msub_3, sc_mmul_3: model_steps = 2'd3;
        default:                         model_steps = 2'd2;
    endcase
endfunction

function automatic logic [DLEN-1:0] carryless_mul(input logic [XLEN-1:0] a,
                                                   input logic [XLEN-1:0] b);
    logic [DLEN-1:0] acc;
    acc = '0;
    for (int i = 0; i < XLEN; i++) begin
        if (b[i]) begin
            acc = acc ^ ({{XLEN{1'b0}}, a} << i);
        end
    end
    return acc;
endfunction

// Fills the expected queues with the words in write order
task automatic predict(input mp_instr_t ins, input logic [XLEN-1:0] gpr);
    mp_subclass_e    sc;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] c;
    logic [DLEN-1:0] res;
    logic            eq_flag;
    sc = ins.r.subclass;
    a = model_regs[ins.r.rs1];
    b = model_regs[ins.r.rs2];
    c = model_regs[ins.r.rs3];
    eq_flag = (b == c) && (gpr != '0);
    res = '0;
    exp_addr_q.delete();
    exp_data_q.delete();
    case (sc)
        sc_mequ:     res = DLEN'(eq_flag);
        sc_mlte:     res = DLEN'((b < c) || eq_flag);
        sc_mgte:     res = DLEN'((b > c) || eq_flag);
        sc_madd_2:   res = {{XLEN{1'b0}}, a} + {{XLEN{1'b0}}, b};
        sc_madd_3:   res = {{XLEN{1'b0}}, a} + {{XLEN{1'b0}}, b} + {{XLEN{1'b0}}, c};
        sc_msub_2:   res = {{XLEN{1'b0}}, a} - {{XLEN{1'b0}}, b};
        sc_msub_3:   res = {{XLEN{1'b0}}, a} - {{XLEN{1'b0}}, b} - DLEN'(c[0]);
        sc_macc_1:   res = {b, c} + {{XLEN{1'b0}}, a};
        sc_mmul_3:   res = {{XLEN{1'b0}}, a} * {{XLEN{1'b0}}, b} + {{XLEN{1'b0}}, c};
        sc_mclmul_3: res = carryless_mul(a, b) ^ {{XLEN{1'b0}}, c};
        sc_msll_i:   res = {b, a} << ins.i.imm4;
        sc_msrl_i:   res = {b, a} >> ins.i.imm4;
        sc_msll:     res = (c[XLEN-1:6] != '0) ? '0 : {b, a} << c[5:0];
        sc_msrl:     res = (c[XLEN-1:6] != '0) ? '0 : {b, a} >> c[5:0];
        default:     res = '0;
    endcase
    if (sc inside {sc_mequ, sc_mlte, sc_mgte}) begin
        exp_addr_q.push_back(ins.r.rd);
        exp_data_q.push_back(res[XLEN-1:0]);
    end else if (sc == sc_macc_1) begin
        exp_addr_q.push_back(ins.r.rs3);
        exp_data_q.push_back(res[XLEN-1:0]);
        exp_addr_q.push_back(ins.r.rs2);
        exp_data_q.push_back(res[DLEN-1:XLEN]);
    end else begin
        exp_addr_q.push_back(ins.r.rd);
        exp_data_q.push_back(res[XLEN-1:0]);
        exp_addr_q.push_back(ins.r.rd + cpr_addr_t'(1));
        exp_data_q.push_back(res[DLEN-1:XLEN]);
    end
endtask

task automatic check_word(input cpr_addr_t exp_addr, input logic [XLEN-1:0] exp_data,
                          input cpr_addr_t got_addr, input logic [XLEN-1:0] got_data);
    if (got_addr !== exp_addr || got_data !== exp_data) begin
        $display("[ERROR] %0t: writeback r%0d = %08h, expected r%0d = %08h",
                 $time, got_addr, got_data, exp_addr, exp_data);
        err_count++;
    end
endtask

task automatic check_latency(input mp_step_t exp_steps, input int cycles);
    int measured;
    measured = cycles - 2;
    if (measured != int'(exp_steps)) begin
        $display("[ERROR] %0t: instruction took %0d steps (%0d cycles), expected %0d steps",
                 $time, measured, cycles, exp_steps);
        err_count++;
    end
endtask

`endif

// File: testbench/tb_mp_cop.sv
`timescale 1ns/1ps
`default_nettype none

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Coprocessor testbench
// Random instructions checked against a model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module tb_mp_cop;

    import mp_core_pkg::*;
    import mp_isa_pkg::*;

    localparam int NUM_TESTS      = 200;
    localparam int TIMEOUT_CYCLES = 20;

    logic            g_clk;
    logic            g_resetn;
    logic            instr_valid_i;
    mp_instr_t       instr_i;
    logic [XLEN-1:0] gpr_rs1_i;
    logic            busy_o;
    logic            host_we_i;
    cpr_addr_t       host_addr_i;
    logic [XLEN-1:0] host_wdata_i;
    logic            wb_valid_o;
    cpr_addr_t       wb_addr_o;
    logic [XLEN-1:0] wb_data_o;
    logic            instr_done_o;

    integer          seed;
    int              err_count;
    int              tests_run;
    int              tests_failed;
    logic            timed_out;
    logic [XLEN-1:0] model_regs [NUM_CPR];
    cpr_addr_t       exp_addr_q [$];
    logic [XLEN-1:0] exp_data_q [$];

    `include "tb_mp_model.svh"

    mp_cop_top u_dut (
        .g_clk         (g_clk),
        .g_resetn      (g_resetn),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .gpr_rs1_i     (gpr_rs1_i),
        .busy_o        (busy_o),
        .host_we_i     (host_we_i),
        .host_addr_i   (host_addr_i),
        .host_wdata_i  (host_wdata_i),
        .wb_valid_o    (wb_valid_o),
        .wb_addr_o     (wb_addr_o),
        .wb_data_o     (wb_data_o),
        .instr_done_o  (instr_done_o)
    );

    always #20 g_clk = ~g_clk;

    // Small values for register shifts, copies for equal compares
    task automatic load_regs();
        logic [XLEN-1:0] val;
        logic [XLEN-1:0] sel;
        for (int a = 0; a < NUM_CPR; a++) begin
            val = $random(seed);
            sel = $random(seed);
            if (sel[1:0] == 2'd0) begin
                val = {26'b0, val[5:0]};
            end else if (sel[1:0] == 2'd1 && a > 0) begin
                val = model_regs[a-1];
            end
            @(posedge g_clk);
            host_we_i    <= 1'b1;
            host_addr_i  <= cpr_addr_t'(a);
            host_wdata_i <= val;
            model_regs[a] = val;
        end
        @(posedge g_clk);
        host_we_i <= 1'b0;
    endtask

    // Host writes that busy_o must block
    task automatic poke_while_busy();
        logic [XLEN-1:0] rnd;
        rnd = $random(seed);
        host_we_i    <= rnd[0];
        host_addr_i  <= rnd[4:1];
        host_wdata_i <= $random(seed);
    endtask

    task automatic run_test(input int idx);
        mp_instr_t       ins;
        logic [XLEN-1:0] rnd;
        logic [XLEN-1:0] gpr;
        logic            done;
        int              cycles;
        int              errs_before;
        cpr_addr_t       got_addr [$];
        logic [XLEN-1:0] got_data [$];
        errs_before = err_count;
        rnd = $random(seed);
        ins = '0;
        ins.r.subclass = mp_subclass_e'(5'(rnd % 32'd14));
        rnd = $random(seed);
        ins.r.rd  = rnd[3:0];
        ins.r.rs1 = rnd[7:4];
        ins.r.rs2 = rnd[11:8];
        ins.r.rs3 = rnd[15:12];
        if (rnd[16] && rnd[17]) begin
            ins.r.rs3 = ins.r.rs2;
        end
        gpr = $random(seed);
        if (rnd[18]) begin
            gpr = '0;
        end
        predict(ins, gpr);

        @(posedge g_clk);
        instr_valid_i <= 1'b1;
        instr_i       <= ins;
        gpr_rs1_i     <= gpr;
        @(posedge g_clk);
        instr_valid_i <= 1'b0;
        poke_while_busy();
        cycles = 0;
        done   = 1'b0;
        while (!done && cycles < TIMEOUT_CYCLES) begin
            @(negedge g_clk);
            cycles++;
            if (!busy_o) begin
                $display("busy_o went low while test %0d was in flight", idx);
                err_count++;
            end
            if (wb_valid_o) begin
                got_addr.push_back(wb_addr_o);
                got_data.push_back(wb_data_o);
            end
            if (instr_done_o) begin
                done = 1'b1;
            end else begin
                @(posedge g_clk);
                poke_while_busy();
            end
        end
        @(posedge g_clk);
        host_we_i <= 1'b0;

        if (!done) begin
            $display("Timeout: instr_done_o missing after %0d cycles in test %0d",
                     TIMEOUT_CYCLES, idx);
            timed_out = 1'b1;
            err_count++;
        end else begin
            check_latency(model_steps(ins.r.subclass), cycles);
            if (got_addr.size() != exp_addr_q.size()) begin
                $display("Test %0d wrote %0d result words instead of %0d",
                         idx, got_addr.size(), exp_addr_q.size());
                err_count++;
            end else begin
                foreach (got_addr[k]) begin
                    check_word(exp_addr_q[k], exp_data_q[k], got_addr[k], got_data[k]);
                end
            end
        end
        // Model follows its own prediction, in write order
        foreach (exp_addr_q[k]) begin
            model_regs[exp_addr_q[k]] = exp_data_q[k];
        end
        tests_run++;
        if (err_count != errs_before) begin
            tests_failed++;
        end
        $display("Test %0d %s: %s", idx, ins.r.subclass.name(),
                 (err_count == errs_before) ? "pass" : "FAIL");
    endtask

    initial begin
        seed          = 32'h3bdcaf0b;
        err_count     = 0;
        tests_run     = 0;
        tests_failed  = 0;
        timed_out     = 1'b0;
        g_clk         = 1'b0;
        g_resetn      = 1'b0;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        gpr_rs1_i     = '0;
        host_we_i     = 1'b0;
        host_addr_i   = '0;
        host_wdata_i  = '0;
        repeat (5) @(posedge g_clk);
        g_resetn <= 1'b1;
        for (int t = 0; t < NUM_TESTS && !timed_out; t++) begin
            // Fresh operands now and then
            if (t % 25 == 0) begin
                load_regs();
            end
            run_test(t);
        end
        $display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, err_count);
        if (err_count == 0 && !timed_out && tests_run == NUM_TESTS) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
+incdir+testbench
rtl/mp_core_pkg.sv
rtl/mp_isa_pkg.sv
rtl/mp_issue_if.sv
rtl/mp_decode.sv
rtl/mp_cpr_file.sv
rtl/mp_malu.sv
rtl/mp_writeback.sv
rtl/mp_cop_top.sv
testbench/tb_mp_cop.sv

// File: Bender.yml
package:
  name: mp_cop

sources:
  - files:
      - rtl/mp_core_pkg.sv
      - rtl/mp_isa_pkg.sv
      - rtl/mp_issue_if.sv
      - rtl/mp_decode.sv
      - rtl/mp_cpr_file.sv
      - rtl/mp_malu.sv
      - rtl/mp_writeback.sv
      - rtl/mp_cop_top.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_mp_cop.sv
